// ==== verilog/dmaPkg.sv ====
package dmaPkg;

  // widths used across the controller
  typedef logic [7:0]  byteT;
  typedef logic [15:0] wordT;
  typedef logic [1:0]  chanT;
  typedef logic [3:0]  chanVecT;
  typedef logic [3:0]  regAddrT;

  // single transfers never need S3
  typedef enum logic [2:0] {
    stSI,
    stSO,
    stS1,
    stS2,
    stS4
  } tcStateT;

  // channel n owns register addresses 2n and 2n+1
  localparam regAddrT regChanAddr    = 4'd0;
  localparam regAddrT regChanCount   = 4'd1;
  localparam regAddrT regCommand     = 4'd8;
  localparam regAddrT regStatus      = 4'd9;
  localparam regAddrT regMaskBit     = 4'd10;
  localparam regAddrT regMode        = 4'd11;
  localparam regAddrT regClearFf     = 4'd12;
  localparam regAddrT regMasterClear = 4'd13;

  // transfer type in mode bits 3:2
  localparam logic [1:0] xferVerify = 2'd0;
  localparam logic [1:0] xferWrite  = 2'd1;
  localparam logic [1:0] xferRead   = 2'd2;

  // bit positions inside command, mode and mask bytes
  localparam int cmdDisableBit    = 2;
  localparam int modeAutoInitBit  = 4;
  localparam int modeDecrementBit = 5;
  localparam int maskValueBit     = 2;

endpackage

// ==== verilog/dmaCpuPort.sv ====
`timescale 1ns/10ps

module dmaCpuPort (
  input  logic            busIf,
  input  logic            rst,
  input  logic            cpuWr,
  input  logic            cpuRd,
  input  dmaPkg::regAddrT cpuAddr,
  input  dmaPkg::byteT    cpuWrData,
  input  dmaPkg::chanVecT dreq,
  input  dmaPkg::chanT    grantChan,
  input  logic            tcStrobe,
  input  dmaPkg::byteT    chanRdByte,
  output dmaPkg::byteT    cpuRdData,
  output logic            cpuRdValid,
  output logic            chanWrStrobe,
  output dmaPkg::chanT    chanSel,
  output logic            hiByte,
  output logic            isCount,
  output dmaPkg::byteT    cpuByte,
  output dmaPkg::chanVecT reqEnabled,
  output logic [1:0]      grantXfer,
  output logic            grantAutoInit,
  output logic            grantDecrement
);

  import dmaPkg::*;

  logic         byteFf;
  byteT         commandReg;
  byteT [3:0]   modeReg;
  chanVecT      maskReg;
  chanVecT      tcFlags;
  logic         isChanReg;
  logic         chanAccess;
  logic         statusRd;
  logic         masterClear;
  chanT         wrChan;
  byteT         rdByte;

  // channel registers fill the lower half of the map
  assign isChanReg   = (cpuAddr[3] == regChanAddr[3]);
  assign chanAccess  = isChanReg && (cpuWr || cpuRd);
  assign statusRd    = cpuRd && (cpuAddr == regStatus);
  assign masterClear = cpuWr && (cpuAddr == regMasterClear);
  assign wrChan      = chanT'(cpuWrData[1:0]);

  // byte lane toward the counters
  assign chanWrStrobe = cpuWr && isChanReg;
  assign chanSel      = cpuAddr[2:1];
  assign isCount      = (cpuAddr[0] == regChanCount[0]);
  assign hiByte       = byteFf;
  assign cpuByte      = cpuWrData;

  // requests pass only when unmasked and the controller is enabled
  assign reqEnabled = commandReg[cmdDisableBit] ? '0 : (dreq & ~maskReg);

  // mode fields of the channel in service
  assign grantXfer      = modeReg[grantChan][3:2];
  assign grantAutoInit  = modeReg[grantChan][modeAutoInitBit];
  assign grantDecrement = modeReg[grantChan][modeDecrementBit];

  always_ff @(posedge busIf) begin
    if (rst || masterClear) begin
      byteFf     <= 1'b0;
      commandReg <= '0;
      modeReg    <= '0;
      maskReg    <= '1;
      tcFlags    <= '0;
    end else begin
      // low byte first, then high byte
      if (chanAccess) begin
        byteFf <= ~byteFf;
      end else if (cpuWr && (cpuAddr == regClearFf)) begin
        byteFf <= 1'b0;
      end
      if (cpuWr && (cpuAddr == regCommand)) begin
        commandReg <= cpuWrData;
      end
      if (cpuWr && (cpuAddr == regMode)) begin
        modeReg[wrChan] <= cpuWrData;
      end
      if (cpuWr && (cpuAddr == regMaskBit)) begin
        maskReg[wrChan] <= cpuWrData[maskValueBit];
      end
      if (statusRd) begin
        tcFlags <= '0;
      end
      // a new terminal count still lands if the status read hits the same cycle
      if (tcStrobe) begin
        tcFlags[grantChan] <= 1'b1;
        if (!modeReg[grantChan][modeAutoInitBit]) begin
          maskReg[grantChan] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    rdByte = '0;
    if (isChanReg) begin
      rdByte = chanRdByte;
    end else if (cpuAddr == regStatus) begin
      rdByte = {dreq, tcFlags};
    end
  end

  always_ff @(posedge busIf) begin
    if (rst) begin
      cpuRdValid <= 1'b0;
    end else begin
      cpuRdValid <= cpuRd;
    end
  end

  always_ff @(posedge busIf) begin
    if (cpuRd) begin
      cpuRdData <= rdByte;
    end
  end

endmodule

// ==== verilog/dmaTimingControl.sv ====
`timescale 1ns/10ps

module dmaTimingControl (
  input  logic            busIf,
  input  logic            rst,
  input  dmaPkg::chanVecT reqEnabled,
  input  logic            hlda,
  input  logic [1:0]      grantXfer,
  input  logic            tcStrobe,
  output dmaPkg::chanT    grantChan,
  output logic            hrq,
  output logic            aen,
  output logic            adstb,
  output dmaPkg::chanVecT dack,
  output logic            ioRdN,
  output logic            ioWrN,
  output logic            memRdN,
  output logic            memWrN,
  output logic            eop,
  output logic            stepStrobe
);

  import dmaPkg::*;

  tcStateT state;
  tcStateT nextState;
  chanT    priChan;
  logic    dackActive;

  // fixed priority where channel 0 wins
  always_comb begin
    priChan = '0;
    for (int i = 3; i >= 0; i--) begin
      if (reqEnabled[i]) begin
        priChan = chanT'(i);
      end
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      stSI: begin
        if (|reqEnabled) begin
          nextState = stSO;
        end
      end
      // hold here until the bus is handed over
      stSO: begin
        if (hlda) begin
          nextState = stS1;
        end
      end
      stS1:    nextState = stS2;
      stS2:    nextState = stS4;
      stS4:    nextState = stSI;
      default: nextState = stSI;
    endcase
  end

  always_ff @(posedge busIf) begin
    if (rst) begin
      state     <= stSI;
      grantChan <= '0;
    end else begin
      state <= nextState;
      if ((state == stSI) && (|reqEnabled)) begin
        grantChan <= priChan;
      end
    end
  end

  assign hrq        = (state != stSI);
  assign aen        = (state == stS1) || (state == stS2) || (state == stS4);
  assign adstb      = (state == stS1);
  assign dackActive = (state == stS2) || (state == stS4);
  assign dack       = dackActive ? (chanVecT'(1) << grantChan) : '0;
  assign stepStrobe = (state == stS4);

  // count test lives in the counters
  assign eop = tcStrobe;

  // read/write strobes only in S2
  always_comb begin
    ioRdN  = 1'b1;
    ioWrN  = 1'b1;
    memRdN = 1'b1;
    memWrN = 1'b1;
    if (state == stS2) begin
      case (grantXfer)
        xferWrite: begin
          ioRdN  = 1'b0;
          memWrN = 1'b0;
        end
        xferRead: begin
          memRdN = 1'b0;
          ioWrN  = 1'b0;
        end
        xferVerify: begin
          // address cycle only
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== verilog/dmaAddressCounters.sv ====
`timescale 1ns/10ps

module dmaAddressCounters (
  input  logic         busIf,
  input  logic         rst,
  input  logic         chanWrStrobe,
  input  dmaPkg::chanT chanSel,
  input  logic         hiByte,
  input  logic         isCount,
  input  dmaPkg::byteT cpuByte,
  input  logic         stepStrobe,
  input  dmaPkg::chanT grantChan,
  input  logic         grantAutoInit,
  input  logic         grantDecrement,
  output dmaPkg::wordT addr,
  output dmaPkg::byteT chanRdByte,
  output logic         tcStrobe
);

  import dmaPkg::*;

  wordT [3:0] baseAddr;
  wordT [3:0] curAddr;
  wordT [3:0] baseCount;
  wordT [3:0] curCount;
  wordT       selWord;
  logic       countZero;

  // terminal count when the count was already zero before this step
  assign countZero = (curCount[grantChan] == '0);
  assign tcStrobe  = stepStrobe && countZero;

  assign addr = curAddr[grantChan];

  // readback always shows the current registers
  assign selWord    = isCount ? curCount[chanSel] : curAddr[chanSel];
  assign chanRdByte = hiByte ? selWord[15:8] : selWord[7:0];

  always_ff @(posedge busIf) begin
    if (rst) begin
      baseAddr  <= '0;
      curAddr   <= '0;
      baseCount <= '0;
      curCount  <= '0;
    end else begin
      if (stepStrobe) begin
        if (countZero && grantAutoInit) begin
          curAddr[grantChan]  <= baseAddr[grantChan];
          curCount[grantChan] <= baseCount[grantChan];
        end else begin
          if (grantDecrement) begin
            curAddr[grantChan] <= curAddr[grantChan] - wordT'(1);
          end else begin
            curAddr[grantChan] <= curAddr[grantChan] + wordT'(1);
          end
          curCount[grantChan] <= curCount[grantChan] - wordT'(1);
        end
      end
      // a CPU write goes to base and current together
      if (chanWrStrobe) begin
        if (isCount) begin
          if (hiByte) begin
            baseCount[chanSel][15:8] <= cpuByte;
            curCount[chanSel][15:8]  <= cpuByte;
          end else begin
            baseCount[chanSel][7:0] <= cpuByte;
            curCount[chanSel][7:0]  <= cpuByte;
          end
        end else begin
          if (hiByte) begin
            baseAddr[chanSel][15:8] <= cpuByte;
            curAddr[chanSel][15:8]  <= cpuByte;
          end else begin
            baseAddr[chanSel][7:0] <= cpuByte;
            curAddr[chanSel][7:0]  <= cpuByte;
          end
        end
      end
    end
  end

endmodule

// ==== verilog/dmaTop.sv ====
`timescale 1ns/10ps

module dmaTop (
  input  logic            busIf,
  input  logic            rst,
  input  logic            cpuWr,
  input  logic            cpuRd,
  input  dmaPkg::regAddrT cpuAddr,
  input  dmaPkg::byteT    cpuWrData,
  output dmaPkg::byteT    cpuRdData,
  output logic            cpuRdValid,
  input  dmaPkg::chanVecT dreq,
  input  logic            hlda,
  output logic            hrq,
  output logic            aen,
  output logic            adstb,
  output dmaPkg::wordT    addr,
  output dmaPkg::chanVecT dack,
  output logic            ioRdN,
  output logic            ioWrN,
  output logic            memRdN,
  output logic            memWrN,
  output logic            eop
);

  import dmaPkg::*;

  // CPU port to counters
  logic       chanWrStrobe;
  chanT       chanSel;
  logic       hiByte;
  logic       isCount;
  byteT       cpuByte;
  byteT       chanRdByte;

  // CPU port to timing control
  chanVecT    reqEnabled;
  logic [1:0] grantXfer;
  logic       grantAutoInit;
  logic       grantDecrement;

  // timing control to counters and back
  chanT       grantChan;
  logic       stepStrobe;
  logic       tcStrobe;

  dmaCpuPort cpuPortInst (
    .busIf          (busIf),
    .rst            (rst),
    .cpuWr          (cpuWr),
    .cpuRd          (cpuRd),
    .cpuAddr        (cpuAddr),
    .cpuWrData      (cpuWrData),
    .dreq           (dreq),
    .grantChan      (grantChan),
    .tcStrobe       (tcStrobe),
    .chanRdByte     (chanRdByte),
    .cpuRdData      (cpuRdData),
    .cpuRdValid     (cpuRdValid),
    .chanWrStrobe   (chanWrStrobe),
    .chanSel        (chanSel),
    .hiByte         (hiByte),
    .isCount        (isCount),
    .cpuByte        (cpuByte),
    .reqEnabled     (reqEnabled),
    .grantXfer      (grantXfer),
    .grantAutoInit  (grantAutoInit),
    .grantDecrement (grantDecrement)
  );

  dmaTimingControl timingInst (
    .busIf      (busIf),
    .rst        (rst),
    .reqEnabled (reqEnabled),
    .hlda       (hlda),
    .grantXfer  (grantXfer),
    .tcStrobe   (tcStrobe),
    .grantChan  (grantChan),
    .hrq        (hrq),
    .aen        (aen),
    .adstb      (adstb),
    .dack       (dack),
    .ioRdN      (ioRdN),
    .ioWrN      (ioWrN),
    .memRdN     (memRdN),
    .memWrN     (memWrN),
    .eop        (eop),
    .stepStrobe (stepStrobe)
  );

  dmaAddressCounters countersInst (
    .busIf          (busIf),
    .rst            (rst),
    .chanWrStrobe   (chanWrStrobe),
    .chanSel        (chanSel),
    .hiByte         (hiByte),
    .isCount        (isCount),
    .cpuByte        (cpuByte),
    .stepStrobe     (stepStrobe),
    .grantChan      (grantChan),
    .grantAutoInit  (grantAutoInit),
    .grantDecrement (grantDecrement),
    .addr           (addr),
    .chanRdByte     (chanRdByte),
    .tcStrobe       (tcStrobe)
  );

endmodule

// ==== verif/dma_checker.sv ====
`timescale 1ns/10ps

module dmaChecker (
  input logic            busIf,
  input logic            rst,
  input logic            hrq,
  input logic            hlda,
  input logic            aen,
  input dmaPkg::chanVecT dack,
  input logic            ioRdN,
  input logic            ioWrN,
  input logic            memRdN,
  input logic            memWrN
);

  int   assertFails = 0;
  logic busActive;

  assign busActive = (|dack) || !ioRdN || !ioWrN || !memRdN || !memWrN;

  dackOneHot: assert property (@(posedge busIf) disable iff (rst) $onehot0(dack))
    else begin
      $error("dack drives more than one channel");
      assertFails = assertFails + 1;
    end

  strobeNeedsAen: assert property (@(posedge busIf) disable iff (rst) busActive |-> aen)
    else begin
      $error("strobe or dack active without aen");
      assertFails = assertFails + 1;
    end

  // bus must be granted before any dack
  dackAfterHold: assert property (@(posedge busIf) disable iff (rst)
    $rose(|dack) |-> ($past(hrq) && $past(hlda)))
    else begin
      $error("dack rose without hrq and hlda");
      assertFails = assertFails + 1;
    end

  resetIdle: assert property (@(posedge busIf) rst |=> (!hrq && (dack == '0)))
    else begin
      $error("hrq or dack active after reset");
      assertFails = assertFails + 1;
    end

endmodule

bind dmaTop dmaChecker checkerInst (
  .busIf  (busIf),
  .rst    (rst),
  .hrq    (hrq),
  .hlda   (hlda),
  .aen    (aen),
  .dack   (dack),
  .ioRdN  (ioRdN),
  .ioWrN  (ioWrN),
  .memRdN (memRdN),
  .memWrN (memWrN)
);

// ==== verif/dmaTb.sv ====
`timescale 1ns/10ps

module dmaTb;

  import dmaPkg::*;

  localparam int waitLimit = 40;

  logic       busIf;
  logic       rst;
  logic       cpuWr;
  logic       cpuRd;
  regAddrT    cpuAddr;
  byteT       cpuWrData;
  byteT       cpuRdData;
  logic       cpuRdValid;
  chanVecT    dreq;
  logic       hlda;
  logic       hrq;
  logic       aen;
  logic       adstb;
  wordT       addr;
  chanVecT    dack;
  logic       ioRdN;
  logic       ioWrN;
  logic       memRdN;
  logic       memWrN;
  logic       eop;
  logic [31:0] rngState;
  byteT       rdData;

  dmaTop dmaTop_inst (
    .busIf      (busIf),
    .rst        (rst),
    .cpuWr      (cpuWr),
    .cpuRd      (cpuRd),
    .cpuAddr    (cpuAddr),
    .cpuWrData  (cpuWrData),
    .cpuRdData  (cpuRdData),
    .cpuRdValid (cpuRdValid),
    .dreq       (dreq),
    .hlda       (hlda),
    .hrq        (hrq),
    .aen        (aen),
    .adstb      (adstb),
    .addr       (addr),
    .dack       (dack),
    .ioRdN      (ioRdN),
    .ioWrN      (ioWrN),
    .memRdN     (memRdN),
    .memWrN     (memWrN),
    .eop        (eop)
  );

  always #2 busIf = ~busIf;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic expectEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stopWithFailure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // inputs change 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge busIf);
    #1;
  endtask

  task automatic writeReg(input regAddrT a, input byteT data);
    cpuWr     = 1'b1;
    cpuAddr   = a;
    cpuWrData = data;
    nextCycle();
    cpuWr = 1'b0;
  endtask

  task automatic readReg(input regAddrT a, output byteT data);
    int cycles;
    cycles  = 0;
    cpuRd   = 1'b1;
    cpuAddr = a;
    nextCycle();
    cpuRd = 1'b0;
    while (!cpuRdValid) begin
      if (cycles >= waitLimit) stopWithFailure("timeout waiting for cpuRdValid");
      nextCycle();
      cycles++;
    end
    data = cpuRdData;
  endtask

  // clear the byte flip-flop so the low byte goes first
  task automatic writeWord(input regAddrT a, input wordT value);
    writeReg(regClearFf, 8'h00);
    writeReg(a, value[7:0]);
    writeReg(a, value[15:8]);
  endtask

  task automatic programChannel(input chanT chan, input byteT mode, input wordT base,
                                input wordT count);
    writeReg(regMode, mode | byteT'(chan));
    writeWord(regAddrT'({chan, 1'b0}), base);
    writeWord(regAddrT'({chan, 1'b1}), count);
    writeReg(regMaskBit, byteT'(chan));
  endtask

  task automatic checkIdle();
    expectEqual("hrq", hrq, 0);
    expectEqual("aen", aen, 0);
    expectEqual("adstb", adstb, 0);
    expectEqual("dack", dack, 0);
    expectEqual("eop", eop, 0);
    expectEqual("cpuRdValid", cpuRdValid, 0);
    expectEqual("strobes", {ioRdN, ioWrN, memRdN, memWrN}, 4'hf);
  endtask

  task automatic expectNoHrq(input chanVecT reqBits);
    dreq = reqBits;
    for (int i = 0; i < waitLimit; i++) begin
      nextCycle();
      expectEqual("hrq", hrq, 0);
    end
    dreq = '0;
  endtask

  // one single transfer where the device drops dreq once it sees dack
  task automatic serviceRequest(input chanVecT reqBits, input chanT chan, input logic [1:0] xfer,
                                input wordT expAddr, input logic expEop, input bit hldaFirst);
    int cycles;
    int delay;
    cycles = 0;
    if (hldaFirst) hlda = 1'b1;
    dreq = dreq | reqBits;
    while (!hrq) begin
      if (cycles >= waitLimit) stopWithFailure("timeout waiting for hrq");
      nextCycle();
      cycles++;
    end
    if (!hldaFirst) begin
      rngState = xorshift(rngState);
      delay    = rngState[1:0];
      repeat (delay) nextCycle();
      hlda = 1'b1;
    end
    while (!adstb) begin
      if (cycles >= waitLimit + 4) stopWithFailure("timeout waiting for adstb");
      nextCycle();
      cycles++;
    end
    expectEqual("aen", aen, 1);
    expectEqual("addr", addr, expAddr);
    nextCycle();
    cycles++;
    if (hldaFirst) expectEqual("dack latency", cycles, 3);
    expectEqual("dack", dack, chanVecT'(1) << chan);
    expectEqual("ioRdN", ioRdN, xfer != xferWrite);
    expectEqual("memWrN", memWrN, xfer != xferWrite);
    expectEqual("memRdN", memRdN, xfer != xferRead);
    expectEqual("ioWrN", ioWrN, xfer != xferRead);
    dreq[chan] = 1'b0;
    nextCycle();
    expectEqual("eop", eop, expEop);
    nextCycle();
    expectEqual("hrq", hrq, 0);
    hlda = 1'b0;
  endtask

  // bound assertions count their failures
  always @(negedge busIf) begin
    if (dmaTop_inst.checkerInst.assertFails != 0) stopWithFailure("protocol assertion failed");
  end

  initial begin
    busIf     = 1'b0;
    rst       = 1'b1;
    cpuWr     = 1'b0;
    cpuRd     = 1'b0;
    cpuAddr   = '0;
    cpuWrData = '0;
    dreq      = '0;
    hlda      = 1'b0;
    rngState  = 32'haa62;
    repeat (16) nextCycle();
    rst = 1'b0;
    nextCycle();

    // reset state with all channels masked
    checkIdle();
    readReg(regStatus, rdData);
    expectEqual("cpuRdData", rdData, 8'h00);
    expectNoHrq(4'b1111);

    // channel 1 moves I/O to memory
    programChannel(2'd1, 8'h04, 16'h3a50, 16'h0005);
    serviceRequest(4'b0010, 2'd1, xferWrite, 16'h3a50, 1'b0, 1'b0);
    serviceRequest(4'b0010, 2'd1, xferWrite, 16'h3a51, 1'b0, 1'b1);

    // channel 0 beats channel 1
    programChannel(2'd0, 8'h08, 16'h0100, 16'h0005);
    serviceRequest(4'b0011, 2'd0, xferRead, 16'h0100, 1'b0, 1'b0);
    serviceRequest(4'b0000, 2'd1, xferWrite, 16'h3a52, 1'b0, 1'b0);

    // channel 2 counts down to terminal count
    programChannel(2'd2, 8'h28, 16'h8000, 16'h0002);
    serviceRequest(4'b0100, 2'd2, xferRead, 16'h8000, 1'b0, 1'b0);
    serviceRequest(4'b0100, 2'd2, xferRead, 16'h7fff, 1'b0, 1'b0);
    serviceRequest(4'b0100, 2'd2, xferRead, 16'h7ffe, 1'b1, 1'b0);
    readReg(regStatus, rdData);
    expectEqual("cpuRdData", rdData, 8'h04);
    readReg(regStatus, rdData);
    expectEqual("cpuRdData", rdData, 8'h00);
    expectNoHrq(4'b0100);

    // channel 3 reloads from base after terminal count
    programChannel(2'd3, 8'h10, 16'h1234, 16'h0001);
    serviceRequest(4'b1000, 2'd3, xferVerify, 16'h1234, 1'b0, 1'b0);
    serviceRequest(4'b1000, 2'd3, xferVerify, 16'h1235, 1'b1, 1'b0);
    writeReg(regClearFf, 8'h00);
    readReg(regAddrT'(7), rdData);
    expectEqual("count low byte", rdData, 8'h01);
    readReg(regAddrT'(7), rdData);
    expectEqual("count high byte", rdData, 8'h00);
    serviceRequest(4'b1000, 2'd3, xferVerify, 16'h1234, 1'b0, 1'b0);

    // controller disable followed by master clear
    writeReg(regCommand, 8'h04);
    expectNoHrq(4'b1000);
    writeReg(regMasterClear, 8'h00);
    nextCycle();
    checkIdle();
    readReg(regStatus, rdData);
    expectEqual("cpuRdData", rdData, 8'h00);
    expectNoHrq(4'b1111);

    if (dmaTop_inst.checkerInst.assertFails == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stopWithFailure("protocol assertion failed");
    end
  end

endmodule

// ==== vlog.f ====
verilog/dmaPkg.sv
verilog/dmaCpuPort.sv
verilog/dmaTimingControl.sv
verilog/dmaAddressCounters.sv
verilog/dmaTop.sv
verif/dma_checker.sv
verif/dmaTb.sv

// ==== Bender.yml ====
package:
  name: dma_ctrl

sources:
  - files:
      - verilog/dmaPkg.sv
      - verilog/dmaCpuPort.sv
      - verilog/dmaTimingControl.sv
      - verilog/dmaAddressCounters.sv
      - verilog/dmaTop.sv
  - target: test
    files:
      - verif/dma_checker.sv
      - verif/dmaTb.sv
